// ==== hdl/osc_pkg.sv ====
// shared types and register field layout for the oscillator
// APB data width is fixed at 32 for the whole design
`default_nettype none

package osc_pkg;

  ////////////////////////////////////////////////////////////
  // voice shape
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    OSC_SQUARE   = 2'd0,
    OSC_TRIANGLE = 2'd1,
    OSC_SAW      = 2'd2,
    OSC_SILENT   = 2'd3  // outputs zero
  } osc_shape_e;

  // word offset inside one voice window
  typedef enum logic [1:0] {
    REG_CTRL      = 2'd0,
    REG_PHASE_INC = 2'd1,
    REG_DUTY      = 2'd2,
    REG_RSVD      = 2'd3  // reads as zero
  } reg_offset_e;

  ////////////////////////////////////////////////////////////
  // control register fields
  ////////////////////////////////////////////////////////////
  localparam int CTRL_EN_BIT    = 0;
  localparam int CTRL_SHAPE_LSB = 1;  // bits 2:1
  localparam int SHAPE_W        = 2;
  localparam int CTRL_ATTEN_LSB = 4;  // bits 6:4
  localparam int ATTEN_W        = 3;

  localparam int VOICE_STRIDE = 16;   // bytes per voice window
  localparam int APB_DATA_W   = 32;

endpackage

`default_nettype wire

// ==== hdl/voice_cfg_if.sv ====
// settings of one voice, driven by the register block
`timescale 1ns/1ns
`default_nettype none

interface voice_cfg_if #(
  parameter int PHASE_W = 24
);

  logic                         en;
  osc_pkg::osc_shape_e          shape;
  logic [osc_pkg::ATTEN_W-1:0]  atten;     // arithmetic right shift
  logic [PHASE_W-1:0]           phase_inc; // added every enabled cycle
  logic [PHASE_W-1:0]           duty;      // square high while phase < duty

  modport regs (
    output en, shape, atten, phase_inc, duty
  );

  modport voice (
    input en, shape, atten, phase_inc, duty
  );

endinterface

`default_nettype wire

// ==== hdl/osc_apb_regs.sv ====
// APB3 slave without wait states or error responses; paddr[1:0] ignored
// needs PHASE_W <= 32 and APB_ADDR_W wide enough to address all voice windows
`timescale 1ns/1ns
`default_nettype none

module osc_apb_regs #(
  parameter int N_VOICES   = 4,
  parameter int PHASE_W    = 24,
  parameter int APB_ADDR_W = 8
)(
  input  wire                                 clk,
  input  wire                                 rst_n,

  input  wire                                 psel,
  input  wire                                 penable,
  input  wire                                 pwrite,
  input  wire        [APB_ADDR_W-1:0]         paddr,
  input  wire        [osc_pkg::APB_DATA_W-1:0] pwdata,
  output logic       [osc_pkg::APB_DATA_W-1:0] prdata,
  output logic                                pready,

  voice_cfg_if.regs                           cfg [N_VOICES]
);

  localparam int IDX_LSB = $clog2(osc_pkg::VOICE_STRIDE);
  localparam int IDX_W   = APB_ADDR_W - IDX_LSB;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////
  logic [IDX_W-1:0]     voice_idx;
  osc_pkg::reg_offset_e reg_off;
  logic                 wr_en;

  assign voice_idx = paddr[APB_ADDR_W-1:IDX_LSB];
  assign reg_off   = osc_pkg::reg_offset_e'(paddr[IDX_LSB-1:2]);
  assign wr_en     = psel && penable && pwrite;  // commits at end of access
  assign pready    = psel && penable;            // never stalls

  // per-voice storage, only the defined bits
  logic [N_VOICES-1:0]                        en_q;
  logic [N_VOICES-1:0][osc_pkg::SHAPE_W-1:0]  shape_q;
  logic [N_VOICES-1:0][osc_pkg::ATTEN_W-1:0]  atten_q;
  logic [N_VOICES-1:0][PHASE_W-1:0]           inc_q;
  logic [N_VOICES-1:0][PHASE_W-1:0]           duty_q;

  logic [osc_pkg::APB_DATA_W-1:0] rd_word;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q    <= '0;
      shape_q <= '0;
      atten_q <= '0;
      inc_q   <= '0;
      duty_q  <= '0;
    end else if (wr_en) begin
      for (int v = 0; v < N_VOICES; v++) begin
        if (voice_idx == IDX_W'(v)) begin  // no match outside the windows
          case (reg_off)
            osc_pkg::REG_CTRL: begin
              en_q[v]    <= pwdata[osc_pkg::CTRL_EN_BIT];
              shape_q[v] <= pwdata[osc_pkg::CTRL_SHAPE_LSB +: osc_pkg::SHAPE_W];
              atten_q[v] <= pwdata[osc_pkg::CTRL_ATTEN_LSB +: osc_pkg::ATTEN_W];
            end
            osc_pkg::REG_PHASE_INC: inc_q[v]  <= pwdata[PHASE_W-1:0];
            osc_pkg::REG_DUTY:      duty_q[v] <= pwdata[PHASE_W-1:0];
            default: ;  // reserved word
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////
  always_comb begin
    rd_word = '0;
    for (int v = 0; v < N_VOICES; v++) begin
      if (voice_idx == IDX_W'(v)) begin
        case (reg_off)
          osc_pkg::REG_CTRL: begin
            rd_word[osc_pkg::CTRL_EN_BIT] = en_q[v];
            rd_word[osc_pkg::CTRL_SHAPE_LSB +: osc_pkg::SHAPE_W] = shape_q[v];
            rd_word[osc_pkg::CTRL_ATTEN_LSB +: osc_pkg::ATTEN_W] = atten_q[v];
          end
          osc_pkg::REG_PHASE_INC: rd_word[PHASE_W-1:0] = inc_q[v];
          osc_pkg::REG_DUTY:      rd_word[PHASE_W-1:0] = duty_q[v];
          default:                rd_word = '0;
        endcase
      end
    end
  end

  // captured in setup phase, valid through access, zero otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prdata <= '0;
    end else if (psel && !penable && !pwrite) begin
      prdata <= rd_word;
    end else begin
      prdata <= '0;
    end
  end

  // fan the stored fields out to the voices
  for (genvar g = 0; g < N_VOICES; g++) begin : g_cfg
    assign cfg[g].en        = en_q[g];
    assign cfg[g].shape     = osc_pkg::osc_shape_e'(shape_q[g]);
    assign cfg[g].atten     = atten_q[g];
    assign cfg[g].phase_inc = inc_q[g];
    assign cfg[g].duty      = duty_q[g];
  end

endmodule

`default_nettype wire

// ==== hdl/osc_voice.sv ====
// one oscillator voice; needs PHASE_W >= WAVE_W
// sample lags the phase by one cycle and is zero while disabled
`timescale 1ns/1ns
`default_nettype none

module osc_voice #(
  parameter int PHASE_W = 24,
  parameter int WAVE_W  = 16
)(
  input  wire                       clk,
  input  wire                       rst_n,

  voice_cfg_if.voice                cfg,

  output logic signed [WAVE_W-1:0]  sample
);

  // full scale, symmetric around zero
  localparam logic signed [WAVE_W-1:0] FS = {1'b0, {(WAVE_W-1){1'b1}}};

  logic [PHASE_W-1:0]        phase;
  logic [WAVE_W-1:0]         u;       // top bits of the phase
  logic [WAVE_W-1:0]         fold;    // doubled ramp, mirrored on second half
  logic signed [WAVE_W-1:0]  shaped;

  assign u    = phase[PHASE_W-1 -: WAVE_W];
  assign fold = u[WAVE_W-1] ? ~(u << 1) : (u << 1);

  ////////////////////////////////////////////////////////////
  // shape select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (cfg.shape)
      osc_pkg::OSC_SQUARE: begin
        shaped = (phase < cfg.duty) ? FS : -FS;
      end
      osc_pkg::OSC_TRIANGLE: begin
        // offset binary to two's complement
        shaped = $signed({~fold[WAVE_W-1], fold[WAVE_W-2:0]});
      end
      osc_pkg::OSC_SAW: begin
        shaped = $signed({~u[WAVE_W-1], u[WAVE_W-2:0]});
      end
      default: begin
        shaped = '0;  // silent
      end
    endcase
  end

  // accumulator wraps mod 2^PHASE_W
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase  <= '0;
      sample <= '0;
    end else if (cfg.en) begin
      phase  <= phase + cfg.phase_inc;
      sample <= shaped >>> cfg.atten;
    end else begin
      sample <= '0;  // phase holds
    end
  end

endmodule

`default_nettype wire

// ==== hdl/osc_mixer.sv ====
// sums all voice samples and clamps to the signed WAVE_W range
`timescale 1ns/1ns
`default_nettype none

module osc_mixer #(
  parameter int N_VOICES = 4,
  parameter int WAVE_W   = 16
)(
  input  wire                                      clk,
  input  wire                                      rst_n,

  input  wire signed [N_VOICES-1:0][WAVE_W-1:0]    samples,
  output logic signed [WAVE_W-1:0]                 waveform
);

  // room for the worst-case sum of all voices
  localparam int SUM_W = WAVE_W + $clog2(N_VOICES) + 1;

  localparam logic signed [WAVE_W-1:0] OUT_MAX = {1'b0, {(WAVE_W-1){1'b1}}};
  localparam logic signed [WAVE_W-1:0] OUT_MIN = {1'b1, {(WAVE_W-1){1'b0}}};

  logic signed [SUM_W-1:0]  sum;
  logic signed [WAVE_W-1:0] clamped;

  ////////////////////////////////////////////////////////////
  // sum and saturate
  ////////////////////////////////////////////////////////////
  always_comb begin
    sum = '0;
    for (int v = 0; v < N_VOICES; v++) begin
      sum = sum + $signed(samples[v]);  // element select is unsigned
    end
  end

  always_comb begin
    if (sum > OUT_MAX) begin
      clamped = OUT_MAX;
    end else if (sum < OUT_MIN) begin
      clamped = OUT_MIN;
    end else begin
      clamped = sum[WAVE_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      waveform <= '0;
    end else begin
      waveform <= clamped;  // one cycle after the samples
    end
  end

endmodule

`default_nettype wire

// ==== hdl/osc_synth_top.sv ====
// multi-voice oscillator with APB3 registers; single clock domain
// phase increments are written by software, no frequency divider
`timescale 1ns/1ns
`default_nettype none

module osc_synth_top #(
  parameter int N_VOICES   = 4,
  parameter int PHASE_W    = 24,
  parameter int WAVE_W     = 16,
  parameter int APB_ADDR_W = 8
)(
  input  wire                                  clk,
  input  wire                                  rst_n,

  // APB3 slave
  input  wire                                  psel,
  input  wire                                  penable,
  input  wire                                  pwrite,
  input  wire        [APB_ADDR_W-1:0]          paddr,
  input  wire        [osc_pkg::APB_DATA_W-1:0] pwdata,
  output logic       [osc_pkg::APB_DATA_W-1:0] prdata,
  output logic                                 pready,

  // mixed output, one sample per cycle
  output logic signed [WAVE_W-1:0]             waveform
);

  logic [N_VOICES-1:0][WAVE_W-1:0] voice_samples;

  voice_cfg_if #(.PHASE_W(PHASE_W)) cfg_if [N_VOICES] ();

  ////////////////////////////////////////////////////////////
  // register block
  ////////////////////////////////////////////////////////////
  osc_apb_regs #(
    .N_VOICES   ( N_VOICES   ),
    .PHASE_W    ( PHASE_W    ),
    .APB_ADDR_W ( APB_ADDR_W )
  ) regs_i0 (
    .clk        ( clk        ), // input
    .rst_n      ( rst_n      ), // input
    .psel       ( psel       ), // input
    .penable    ( penable    ), // input
    .pwrite     ( pwrite     ), // input
    .paddr      ( paddr      ), // input
    .pwdata     ( pwdata     ), // input
    .prdata     ( prdata     ), // output
    .pready     ( pready     ), // output
    .cfg        ( cfg_if     )  // one interface per voice
  );

  ////////////////////////////////////////////////////////////
  // voices
  ////////////////////////////////////////////////////////////
  for (genvar g = 0; g < N_VOICES; g++) begin : g_voice
    osc_voice #(
      .PHASE_W ( PHASE_W          ),
      .WAVE_W  ( WAVE_W           )
    ) voice_i (
      .clk     ( clk              ), // input
      .rst_n   ( rst_n            ), // input
      .cfg     ( cfg_if[g]        ),
      .sample  ( voice_samples[g] )  // output
    );
  end

  // mixer, registered and saturated
  osc_mixer #(
    .N_VOICES ( N_VOICES      ),
    .WAVE_W   ( WAVE_W        )
  ) mixer_i0 (
    .clk      ( clk           ), // input
    .rst_n    ( rst_n         ), // input
    .samples  ( voice_samples ), // input
    .waveform ( waveform      )  // output
  );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
// free-running testbench clock, starts low
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 4  // ns
)(
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== test/osc_synth_props.sv ====
// checks on the APB handshake, read data after reset and a silent output
// fail_cnt counts assertion failures for the testbench
`timescale 1ns/1ns
`default_nettype none

module osc_synth_props #(
  parameter int N_VOICES = 4,
  parameter int WAVE_W   = 16
)(
  input wire                           clk,
  input wire                           rst_n,
  input wire                           psel,
  input wire                           penable,
  input wire                           pready,
  input wire [osc_pkg::APB_DATA_W-1:0] prdata,
  input wire [N_VOICES-1:0]            voice_en,
  input wire signed [WAVE_W-1:0]       waveform
);

  int fail_cnt = 0;

  // no wait states
  a_pready: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable) |-> pready)
    else begin
      $error("pready low in an access phase");
      fail_cnt++;
    end

  a_prdata_rst: assert property (@(posedge clk) $rose(rst_n) |=> (prdata == '0))
    else begin
      $error("prdata not zero one cycle after reset");
      fail_cnt++;
    end

  // voice register, then mixer register
  a_silent: assert property (@(posedge clk) disable iff (!rst_n)
    (voice_en == '0) |-> ##2 (waveform == '0))
    else begin
      $error("waveform not zero with all voices disabled");
      fail_cnt++;
    end

endmodule

bind osc_synth_top osc_synth_props #(
  .N_VOICES ( N_VOICES     ),
  .WAVE_W   ( WAVE_W       )
) props0 (
  .clk      ( clk          ),
  .rst_n    ( rst_n        ),
  .psel     ( psel         ),
  .penable  ( penable      ),
  .pready   ( pready       ),
  .prdata   ( prdata       ),
  .voice_en ( regs_i0.en_q ),
  .waveform ( waveform     )
);

`default_nettype wire

// ==== test/osc_synth_tb.sv ====
// directed tests of the oscillator top level at its default parameters
// inputs change 1 ns after the rising edge, outputs are read there too
`timescale 1ns/1ns
`default_nettype none

module osc_synth_tb;

  localparam int PHASE_W = 24;
  localparam int WAVE_W  = 16;
  localparam int N_V     = 4;
  localparam int FS      = (1 << (WAVE_W - 1)) - 1;
  localparam int TIMEOUT = 20;  // cycles
  localparam logic [31:0] CTRL_MASK = (32'd1 << osc_pkg::CTRL_EN_BIT)
      | (32'd3 << osc_pkg::CTRL_SHAPE_LSB) | (32'd7 << osc_pkg::CTRL_ATTEN_LSB);
  localparam logic [31:0] FIELD_MASK = (32'd1 << PHASE_W) - 1;

  logic                     clk;
  logic                     rst_n;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [7:0]               paddr;
  logic [31:0]              pwdata;
  wire  [31:0]              prdata;
  wire                      pready;
  wire  signed [WAVE_W-1:0] waveform;
  logic [31:0]              lcg_state = 32'h1a1915f3;

  tb_clk_gen #(.PERIOD(4)) clk_gen0 (.clk(clk));

  osc_synth_top dut0 (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .psel     ( psel     ),
    .penable  ( penable  ),
    .pwrite   ( pwrite   ),
    .paddr    ( paddr    ),
    .pwdata   ( pwdata   ),
    .prdata   ( prdata   ),
    .pready   ( pready   ),
    .waveform ( waveform )
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [7:0] reg_addr(input int voice, input osc_pkg::reg_offset_e off);
    return 8'(voice * osc_pkg::VOICE_STRIDE + int'(off) * 4);
  endfunction

  function automatic logic [31:0] ctrl_word(input logic en, input osc_pkg::osc_shape_e shape,
                                            input int atten);
    return (32'(en) << osc_pkg::CTRL_EN_BIT) | (32'(shape) << osc_pkg::CTRL_SHAPE_LSB)
         | (32'(atten) << osc_pkg::CTRL_ATTEN_LSB);
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic next_sample(output int s);
    @(posedge clk);
    #1;
    s = waveform;  // sign extended
  endtask

  ////////////////////////////////////////////////////////////
  // APB3 master
  ////////////////////////////////////////////////////////////
  task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] data);
    int n;
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    check_eq("pready in setup phase", pready, 0);
    #1;
    penable = 1'b1;
    n = 0;
    #1;  // pready is combinational
    while (pready !== 1'b1) begin
      if (n == TIMEOUT) begin
        stop_run("ERROR: pready stayed low in the access phase");
      end
      n++;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic apb_end();
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_access(addr, 1'b1, data);
    apb_end();  // write commits at this edge
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    apb_access(addr, 1'b0, '0);
    data = prdata;
    apb_end();
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic test_readback();
    logic [31:0] wr_val [N_V][3];
    logic [31:0] got;
    logic [7:0]  far_addr [4] = '{8'h40, 8'h4c, 8'ha4, 8'hfc};
    for (int v = 0; v < N_V; v++) begin
      for (int r = 0; r < 3; r++) begin
        wr_val[v][r] = lcg_next();
        apb_write(reg_addr(v, osc_pkg::reg_offset_e'(r)), wr_val[v][r]);
      end
    end
    for (int v = 0; v < N_V; v++) begin
      for (int r = 0; r < 3; r++) begin
        apb_read(reg_addr(v, osc_pkg::reg_offset_e'(r)), got);
        check_eq($sformatf("prdata voice %0d word %0d", v, r), got,
                 wr_val[v][r] & ((r == 0) ? CTRL_MASK : FIELD_MASK));
      end
      apb_read(reg_addr(v, osc_pkg::REG_RSVD), got);
      check_eq($sformatf("prdata voice %0d reserved", v), got, 0);
    end
    foreach (far_addr[i]) begin
      apb_read(far_addr[i], got);
      check_eq($sformatf("prdata at 0x%02h", far_addr[i]), got, 0);
    end
    for (int v = 0; v < N_V; v++) begin
      apb_write(reg_addr(v, osc_pkg::REG_CTRL), 0);
    end
  endtask

  task automatic test_silence();
    int s;
    wait_cycles(3);
    repeat (64) begin
      next_sample(s);
      check_eq("waveform all off", s, 0);
    end
    apb_write(reg_addr(0, osc_pkg::REG_PHASE_INC), 32'h012345);
    apb_write(reg_addr(0, osc_pkg::REG_CTRL), ctrl_word(1'b1, osc_pkg::OSC_SILENT, 0));
    wait_cycles(3);
    repeat (64) begin
      next_sample(s);
      check_eq("waveform silent shape", s, 0);
    end
    apb_write(reg_addr(0, osc_pkg::REG_CTRL), 0);
  endtask

  task automatic test_square_duty();
    int s;
    int high;
    apb_write(reg_addr(1, osc_pkg::REG_PHASE_INC), 32'd1 << (PHASE_W - 6));  // 64 cycles
    apb_write(reg_addr(1, osc_pkg::REG_DUTY), 32'd1 << (PHASE_W - 2));
    apb_write(reg_addr(1, osc_pkg::REG_CTRL), ctrl_word(1'b1, osc_pkg::OSC_SQUARE, 0));
    wait_cycles(3);
    high = 0;
    repeat (64) begin
      next_sample(s);
      if (s == FS) begin
        high++;
      end else begin
        check_eq("waveform square", s, -FS);
      end
    end
    check_eq("square high count", high, 16);
    apb_write(reg_addr(1, osc_pkg::REG_CTRL), 0);
  endtask

  // step between successive samples of a ramp on voice 2
  task automatic test_ramp(input osc_pkg::osc_shape_e shape, input int atten);
    int k;
    int step;
    int tol;
    int lim;
    int prev;
    int s;
    int diff;
    k    = 128 + int'(lcg_next() % 32'd256);
    step = ((shape == osc_pkg::OSC_SAW) ? k : 2 * k) >> atten;
    tol  = (atten == 0) ? 0 : 1;
    lim  = (FS >> atten) - step - 2;  // turns only happen beyond this
    apb_write(reg_addr(2, osc_pkg::REG_PHASE_INC), k << (PHASE_W - WAVE_W));
    apb_write(reg_addr(2, osc_pkg::REG_CTRL), ctrl_word(1'b1, shape, atten));
    wait_cycles(3);
    next_sample(prev);
    repeat (600) begin
      next_sample(s);
      diff = s - prev;
      if (shape == osc_pkg::OSC_SAW && diff < 0) begin
        diff = diff + (1 << (WAVE_W - atten));  // wrap from top to bottom
      end else if (shape == osc_pkg::OSC_TRIANGLE) begin
        if (diff < 0) begin
          diff = -diff;  // falling half
        end
        if ((prev >= lim || prev <= -lim) && diff <= step + 2) begin
          diff = step;  // turn at a peak
        end
      end
      if (diff >= step - tol && diff <= step + tol) begin
        diff = step;
      end
      check_eq($sformatf("waveform step, shape %0d atten %0d", shape, atten), diff, step);
      prev = s;
    end
    apb_write(reg_addr(2, osc_pkg::REG_CTRL), 0);
  endtask

  task automatic test_mixing();
    int s;
    reset_dut();  // phases back to zero
    for (int a = 0; a < 2; a++) begin
      apb_write(reg_addr(0, osc_pkg::REG_DUTY), 1);
      apb_write(reg_addr(3, osc_pkg::REG_DUTY), 1);
      apb_write(reg_addr(0, osc_pkg::REG_CTRL), ctrl_word(1'b1, osc_pkg::OSC_SQUARE, a));
      apb_write(reg_addr(3, osc_pkg::REG_CTRL), ctrl_word(1'b1, osc_pkg::OSC_SQUARE, a));
      wait_cycles(3);
      next_sample(s);
      check_eq($sformatf("waveform mix atten %0d", a), s, (a == 0) ? FS : 2 * (FS >> 1));
    end
  endtask

  initial begin
    int atten;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    reset_dut();
    test_readback();
    test_silence();
    test_square_duty();
    atten = 1 + int'(lcg_next() % 32'd3);
    test_ramp(osc_pkg::OSC_SAW, 0);
    test_ramp(osc_pkg::OSC_SAW, atten);
    test_ramp(osc_pkg::OSC_TRIANGLE, 0);
    test_ramp(osc_pkg::OSC_TRIANGLE, atten);
    test_mixing();
    if (dut0.props0.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_run("ERROR: a bound assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/osc_pkg.sv
hdl/voice_cfg_if.sv
hdl/osc_apb_regs.sv
hdl/osc_voice.sv
hdl/osc_mixer.sv
hdl/osc_synth_top.sv
test/tb_clk_gen.sv
test/osc_synth_props.sv
test/osc_synth_tb.sv
